// ==== build.f ====
+incdir+hw
hw/mac_pkg.sv
hw/vedic_mult.sv
hw/hamming_enc.sv
hw/hamming_dec.sv
hw/ecc_acc_store.sv
hw/mac_ctrl.sv
hw/err_log.sv
hw/ecc_mac_top.sv
bench/ecc_mac_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := ecc_mac_tb
FILELIST  := build.f
FLAGS     := --binary --timing --top-module $(TOP)
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) hw/mac_macros.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/ecc_mac_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module ecc_mac_tb;

    import mac_pkg::*;

    // About 330 operations at 5 cycles each, plus injections and margin
    localparam int MAX_CYCLES = 2000;
    localparam int ACK_WAIT   = 16;

    logic        clk;
    logic        rst_n;
    logic        req;
    mac_req_t    op;
    logic        err_clear;
    codeword_t   fault_mask;
    logic        ack;
    acc_t        acc;
    err_status_t err;

    acc_t         model_acc;
    err_count_t   model_count;
    cycle_stamp_t model_last;
    cycle_stamp_t model_cycle;
    logic         pending_err;
    int           errors;
    int           ops_done;
    int           cycles = 0;

    ecc_mac_top ecc_mac_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .op         (op),
        .err_clear  (err_clear),
        .fault_mask (fault_mask),
        .ack        (ack),
        .acc        (acc),
        .err        (err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Counts rising edges since reset release and wraps like the stamp
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_cycle <= '0;
        end else begin
            model_cycle <= model_cycle + cycle_stamp_t'(1);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d, operations: %0d", errors, ops_done);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, expected);
        errors++;
    endtask

    // One four-phase transfer where hold keeps req high for extra cycles after ack
    task automatic do_op(input operand_t op_a, input operand_t op_b, input logic clr,
                         input int hold);
        acc_t         product;
        cycle_stamp_t stamp;
        int           edges;
        product = acc_t'(op_a) * acc_t'(op_b);
        stamp   = '0;
        edges   = 0;
        @(posedge clk);
        op  <= '{a: op_a, b: op_b, clear: clr};
        req <= 1'b1;
        @(negedge clk);
        while (!ack && edges < ACK_WAIT) begin
            stamp = model_cycle;
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (!ack) begin
            $display("ack never rose within %0d cycles of req", ACK_WAIT);
            errors++;
            @(posedge clk);
            req <= 1'b0;
            return;
        end
        if (edges != 2) begin
            $display("ack rose %0d edges after req instead of 2", edges);
            errors++;
        end
        if (clr) begin
            model_acc = product;
        end else begin
            model_acc = model_acc + product;
        end
        // A pending upset is logged and scrubbed by this write
        if (pending_err) begin
            if (model_count != '1) begin
                model_count = model_count + err_count_t'(1);
            end
            model_last  = stamp;
            pending_err = 1'b0;
        end
        ops_done++;
        if (acc !== model_acc) report_mismatch("acc", 32'(acc), 32'(model_acc));
        if (err.count !== model_count) begin
            report_mismatch("err.count", 32'(err.count), 32'(model_count));
        end
        if (err.last_cycle !== model_last) begin
            report_mismatch("err.last_cycle", 32'(err.last_cycle), 32'(model_last));
        end
        if (err.detected !== 1'b0) report_mismatch("err.detected", 32'(err.detected), 32'h0);
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            @(negedge clk);
            if (ack !== 1'b1) report_mismatch("ack", 32'(ack), 32'h1);
            if (acc !== model_acc) report_mismatch("acc", 32'(acc), 32'(model_acc));
        end
        @(posedge clk);
        req   <= 1'b0;
        edges = 0;
        @(negedge clk);
        while (ack && edges < ACK_WAIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (ack) begin
            $display("ack never fell after req dropped");
            errors++;
        end else if (edges != 1) begin
            $display("ack fell %0d edges after req dropped instead of 1", edges);
            errors++;
        end
    endtask

    // Flips one stored bit for a single idle cycle
    task automatic inject_fault(input int pos);
        @(posedge clk);
        fault_mask <= codeword_t'(1) << pos;
        @(posedge clk);
        fault_mask  <= '0;
        pending_err = 1'b1;
        @(negedge clk);
        if (err.detected !== 1'b1) report_mismatch("err.detected", 32'(err.detected), 32'h1);
        if (acc !== model_acc) report_mismatch("acc", 32'(acc), 32'(model_acc));
    endtask

    task automatic check_handshake();
        if (ack !== 1'b0) report_mismatch("ack", 32'(ack), 32'h0);
        if (err.count !== '0) report_mismatch("err.count", 32'(err.count), 32'h0);
        if (acc !== '0) report_mismatch("acc", 32'(acc), 32'h0);
        do_op(8'hff, 8'hff, 1'b1, 4);
        do_op(operand_t'($urandom), operand_t'($urandom), 1'b0, 0);
    endtask

    task automatic multiply_load(input int count);
        for (int i = 0; i < count; i++) begin
            do_op(operand_t'($urandom), operand_t'($urandom), 1'b1, 0);
        end
    endtask

    task automatic accumulate(input int count);
        for (int i = 0; i < count; i++) begin
            do_op(operand_t'($urandom), operand_t'($urandom), ($urandom % 16) == 0, 0);
        end
    endtask

    task automatic single_bit_correction();
        for (int pos = 0; pos < `MAC_CW_W; pos++) begin
            inject_fault(pos);
            do_op(operand_t'($urandom), operand_t'($urandom), 1'b0, 0);
        end
    endtask

    task automatic saturate_and_clear();
        for (int i = 0; i < 4; i++) begin
            inject_fault(int'($urandom % `MAC_CW_W));
            do_op(operand_t'($urandom), operand_t'($urandom), 1'b0, 0);
        end
        if (err.count !== 4'hf) report_mismatch("err.count", 32'(err.count), 32'hf);
        @(posedge clk);
        err_clear <= 1'b1;
        @(posedge clk);
        err_clear   <= 1'b0;
        model_count = '0;
        @(negedge clk);
        if (err.count !== '0) report_mismatch("err.count", 32'(err.count), 32'h0);
        if (err.last_cycle !== model_last) begin
            report_mismatch("err.last_cycle", 32'(err.last_cycle), 32'(model_last));
        end
    endtask

    initial begin
        void'($urandom(32'hb977));
        rst_n       = 1'b0;
        req         = 1'b0;
        op          = '0;
        err_clear   = 1'b0;
        fault_mask  = '0;
        model_acc   = '0;
        model_count = '0;
        model_last  = '0;
        pending_err = 1'b0;
        errors      = 0;
        ops_done    = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_handshake();
        multiply_load(100);
        accumulate(200);
        single_bit_correction();
        saturate_and_clear();
        $display("errors: %0d, operations: %0d", errors, ops_done);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/ecc_mac_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module ecc_mac_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     req,
    input  wire mac_pkg::mac_req_t  op,
    input  wire                     err_clear,
    input  wire mac_pkg::codeword_t fault_mask,
    output logic                    ack,
    output mac_pkg::acc_t           acc,
    output mac_pkg::err_status_t    err
);

    import mac_pkg::*;

    operand_t a;
    operand_t b;
    logic     clear;
    logic     step;
    logic     detected;
    acc_t     product;

    mac_ctrl mac_ctrl_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .op    (op),
        .ack   (ack),
        .step  (step),
        .a     (a),
        .b     (b),
        .clear (clear)
    );

    vedic_mult #(.WIDTH(`MAC_OP_W)) vedic_mult_i (
        .a (a),
        .b (b),
        .p (product)
    );

    ecc_acc_store ecc_acc_store_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (step),
        .clear      (clear),
        .product    (product),
        .fault_mask (fault_mask),
        .acc        (acc),
        .detected   (detected)
    );

    err_log err_log_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .detected  (detected),
        .err_clear (err_clear),
        .status    (err)
    );

endmodule

`default_nettype wire

// ==== hw/err_log.sv ====
`timescale 1ns/1ps
`default_nettype none

module err_log (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  step,
    input  wire                  detected,
    input  wire                  err_clear,
    output mac_pkg::err_status_t status
);

    import mac_pkg::*;

    cycle_stamp_t cycle_q;
    err_count_t   count_q;
    cycle_stamp_t last_q;
    logic         log_err;

    // One upset is logged once, at the write that scrubs it
    assign log_err = step & detected;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_q <= '0;
            count_q <= '0;
            last_q  <= '0;
        end else begin
            cycle_q <= cycle_q + cycle_stamp_t'(1);
            if (err_clear) begin
                count_q <= '0;
            end else if (log_err && count_q != '1) begin
                count_q <= count_q + err_count_t'(1);
            end
            if (log_err) begin
                last_q <= cycle_q;
            end
        end
    end

    assign status.detected   = detected;
    assign status.count      = count_q;
    assign status.last_cycle = last_q;

endmodule

`default_nettype wire

// ==== hw/mac_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_ctrl (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    req,
    input  wire mac_pkg::mac_req_t op,
    output logic                   ack,
    output logic                   step,
    output mac_pkg::operand_t      a,
    output mac_pkg::operand_t      b,
    output logic                   clear
);

    import mac_pkg::*;

    ctrl_state_t state_q;
    mac_req_t    op_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req) begin
                        state_q <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    state_q <= HOLD;
                end
                HOLD: begin
                    // Waits here as long as the master keeps req high
                    if (!req) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Request is captured on the edge that leaves IDLE
    always_ff @(posedge clk) begin
        if (state_q == IDLE && req) begin
            op_q <= op;
        end
    end

    // The accumulator write happens on the edge that leaves COMPUTE
    assign step  = (state_q == COMPUTE);
    assign ack   = (state_q == HOLD);
    assign a     = op_q.a;
    assign b     = op_q.b;
    assign clear = op_q.clear;

endmodule

`default_nettype wire

// ==== hw/ecc_acc_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_acc_store (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     step,
    input  wire                     clear,
    input  wire mac_pkg::acc_t      product,
    input  wire mac_pkg::codeword_t fault_mask,
    output mac_pkg::acc_t           acc,
    output logic                    detected
);

    import mac_pkg::*;

    acc_t      sum;
    codeword_t next_cw;
    codeword_t stored;

    // Adds to the corrected value, so a write also scrubs a single upset
    assign sum = clear ? product : acc + product;

    hamming_enc enc_i (
        .data (sum),
        .cw   (next_cw)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stored <= '0;
        end else if (step) begin
            stored <= next_cw;
        end else begin
            // Self-test path, flips stored bits while no write is due
            stored <= stored ^ fault_mask;
        end
    end

    hamming_dec dec_i (
        .cw       (stored),
        .data     (acc),
        .detected (detected)
    );

endmodule

`default_nettype wire

// ==== hw/hamming_dec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module hamming_dec (
    input  wire mac_pkg::codeword_t cw,
    output mac_pkg::acc_t           data,
    output logic                    detected
);

    import mac_pkg::*;

    syndrome_t syndrome;

    always_comb begin
        for (int i = 0; i < `MAC_SYN_W; i++) begin
            syndrome[i] = parity_of(cw, i) ^ cw[(1 << i) - 1];
        end
    end

    assign detected = (syndrome != '0);

    // Syndrome gives the 1-based position of a single flipped bit.
    // Only data positions are gathered, so parity hits and 22..31 leave data as is
    always_comb begin
        int d;
        d    = 0;
        data = '0;
        for (int pos = 1; pos <= `MAC_CW_W; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                data[d] = (pos == int'(syndrome)) ? ~cw[pos-1] : cw[pos-1];
                d++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/hamming_enc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module hamming_enc (
    input  wire mac_pkg::acc_t      data,
    output mac_pkg::codeword_t      cw
);

    import mac_pkg::*;

    always_comb begin
        codeword_t word;
        int        d;
        word = '0;
        d    = 0;
        // Data fills every position that is not a power of two
        for (int pos = 1; pos <= `MAC_CW_W; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                word[pos-1] = data[d];
                d++;
            end
        end
        for (int i = 0; i < `MAC_SYN_W; i++) begin
            word[(1 << i) - 1] = parity_of(word, i);
        end
        cw = word;
    end

endmodule

`default_nettype wire

// ==== hw/vedic_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

module vedic_mult #(
    parameter int WIDTH = 8
) (
    input  wire  [WIDTH-1:0]   a,
    input  wire  [WIDTH-1:0]   b,
    output logic [2*WIDTH-1:0] p
);

    if (WIDTH == 2) begin : gen_leaf
        logic cross_lo;
        logic cross_hi;
        logic carry;

        assign cross_lo = a[1] & b[0];
        assign cross_hi = a[0] & b[1];
        assign carry    = cross_lo & cross_hi;

        assign p[0] = a[0] & b[0];
        assign p[1] = cross_lo ^ cross_hi;
        assign p[2] = (a[1] & b[1]) ^ carry;
        assign p[3] = a[1] & b[1] & carry;
    end else begin : gen_split
        localparam int H = WIDTH / 2;

        logic [WIDTH-1:0]   ll;
        logic [WIDTH-1:0]   lh;
        logic [WIDTH-1:0]   hl;
        logic [WIDTH-1:0]   hh;
        logic [WIDTH+H-1:0] upper;

        // Vertical products on the diagonal, crosswise products in the middle
        vedic_mult #(.WIDTH(H)) ll_i (.a(a[H-1:0]),     .b(b[H-1:0]),     .p(ll));
        vedic_mult #(.WIDTH(H)) lh_i (.a(a[H-1:0]),     .b(b[WIDTH-1:H]), .p(lh));
        vedic_mult #(.WIDTH(H)) hl_i (.a(a[WIDTH-1:H]), .b(b[H-1:0]),     .p(hl));
        vedic_mult #(.WIDTH(H)) hh_i (.a(a[WIDTH-1:H]), .b(b[WIDTH-1:H]), .p(hh));

        // Low H bits of ll pass straight through
        assign upper = {hh, ll[WIDTH-1:H]} + (WIDTH+H)'(lh) + (WIDTH+H)'(hl);
        assign p     = {upper, ll[H-1:0]};
    end

endmodule

`default_nettype wire

// ==== hw/mac_pkg.sv ====
`default_nettype none

`include "mac_macros.svh"

package mac_pkg;

    typedef logic [`MAC_OP_W-1:0]    operand_t;
    typedef logic [`MAC_ACC_W-1:0]   acc_t;
    typedef logic [`MAC_CW_W-1:0]    codeword_t;
    typedef logic [`MAC_SYN_W-1:0]   syndrome_t;
    typedef logic [`MAC_CNT_W-1:0]   err_count_t;
    typedef logic [`MAC_STAMP_W-1:0] cycle_stamp_t;

    typedef struct packed {
        operand_t a;
        operand_t b;
        logic     clear;
    } mac_req_t;

    typedef struct packed {
        logic         detected;
        err_count_t   count;
        cycle_stamp_t last_cycle;
    } err_status_t;

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        HOLD
    } ctrl_state_t;

    // Positions are numbered from 1; the parity bit of group idx sits at 2**idx
    function automatic logic parity_of(codeword_t cw, int unsigned idx);
        logic p;
        p = 1'b0;
        for (int pos = 1; pos <= `MAC_CW_W; pos++) begin
            if (pos[idx] && pos != (1 << idx)) begin
                p ^= cw[pos-1];
            end
        end
        return p;
    endfunction

endpackage

`default_nettype wire

// ==== hw/mac_macros.svh ====
`ifndef MAC_MACROS_SVH
`define MAC_MACROS_SVH

// Multiplier operand width
`define MAC_OP_W 8

// Product and accumulator width
`define MAC_ACC_W 16

// Hamming (21,16) codeword and syndrome widths
`define MAC_CW_W 21
`define MAC_SYN_W 5

// Error log widths
`define MAC_CNT_W 4
`define MAC_STAMP_W 8

`endif
